// ==== sym_vn_lut.f ====
+incdir+logic
logic/vn_lut_pkg.sv
logic/vn_msg_fold.sv
logic/vn_lut_bank.sv
logic/vn_msg_unfold.sv
logic/sym_vn_lut.sv
tests/tb_clock.sv
tests/tb_sym_vn_lut.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_sym_vn_lut -f sym_vn_lut.f -o tb_sym_vn_lut \
	&& ./obj_dir/tb_sym_vn_lut | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== tests/vn_lut_patterns.txt ====
// off | port A: y0 y1 te bank page(2 digits) msb | port B: y0 y1 te bank page(2 digits) msb
// One hex digit per field except page; msb is the expected transpose_en_out
035001d06901310
19401331ca001d1
017110813a101d1
1c5101d0fe11060
0000000080013f1
17f013f02c01140
0a3102b056002e0
1d1011614b10241
0e8110806311341
1bf112701d010d0
1ca001d135001d0
080013f17f013f0
03a101d1c5101d0
169013100000000
12c01140a3102b0
056002e0d101161
14b10241e811080
06311341bf11270
01d010d09401331
1fe110601711081
035001d0ca001d1
17f013f080013f1

// ==== tests/tb_sym_vn_lut.sv ====
`timescale 1ns/1ns
`include "vn_lut_macros.svh"

module tb_sym_vn_lut;

	localparam int n_pat = 22;
	localparam int n_entries = 2*`VN_PAGES;
	localparam int latency = 3;
	// Reset, table fill, vectors and drain, plus margin
	localparam int cycle_limit = 16 + n_entries + n_pat + latency + 50;

	// One port's columns of a pattern line
	typedef struct packed {
		logic [3:0] y0;
		logic [3:0] y1;
		logic [3:0] te;
		logic [3:0] bank;
		logic [7:0] page;
		logic [3:0] msb;
	} port_vec_t;

	typedef struct packed {
		logic [3:0] off;
		port_vec_t a;
		port_vec_t b;
	} pattern_t;

	logic read_clk;
	logic rst_n;
	vn_lut_pkg::msg_t y0_a, y1_a, y0_b, y1_b;
	logic transpose_en_in_a, transpose_en_in_b, read_addr_offset;
	vn_lut_pkg::lut_word_t lut_in_bank0, lut_in_bank1;
	vn_lut_pkg::page_t page_write_addr;
	logic write_addr_offset, we;
	vn_lut_pkg::lut_word_t t_c_a, t_c_din_a, t_c_b, t_c_din_b;
	logic transpose_en_out_a, transpose_en_out_b, read_addr_offset_out;

	// Reference copy of the table, index is offset over page
	vn_lut_pkg::lut_word_t model0 [n_entries];
	vn_lut_pkg::lut_word_t model1 [n_entries];
	logic [59:0] pat_mem [n_pat];
	// Pattern index per falling edge, -1 marks an idle slot
	int pend_q [$];
	int value_errors = 0;
	int other_errors = 0;
	int cycle_count = 0;

	tb_clock i_clock (.read_clk(read_clk), .rst_n(rst_n));

	sym_vn_lut i_dut (
		.read_clk(read_clk), .rst_n(rst_n),
		.y0_a(y0_a), .y1_a(y1_a), .y0_b(y0_b), .y1_b(y1_b),
		.transpose_en_in_a(transpose_en_in_a), .transpose_en_in_b(transpose_en_in_b),
		.read_addr_offset(read_addr_offset),
		.lut_in_bank0(lut_in_bank0), .lut_in_bank1(lut_in_bank1),
		.page_write_addr(page_write_addr), .write_addr_offset(write_addr_offset), .we(we),
		.t_c_a(t_c_a), .t_c_din_a(t_c_din_a), .t_c_b(t_c_b), .t_c_din_b(t_c_din_b),
		.transpose_en_out_a(transpose_en_out_a), .transpose_en_out_b(transpose_en_out_b),
		.read_addr_offset_out(read_addr_offset_out)
	);

	////////////////////
	// Checks
	////////////////////

	task automatic compare(input string name, input logic [3:0] got, input logic [3:0] exp,
		input string where);
		if (got !== exp) begin
			$display("error: %s got %h expected %h at %s", name, got, exp, where);
			value_errors++;
		end
	endtask

	// Expected words come from the model at the file's bank, page and offset
	task automatic check_port(input string port, input port_vec_t e, input logic off,
		input vn_lut_pkg::lut_word_t tc, input vn_lut_pkg::lut_word_t din, input logic te_out,
		input string where);
		logic [6:0] idx;
		vn_lut_pkg::lut_word_t exp_din;
		idx = {off, e.page[5:0]};
		exp_din = e.bank[0] ? model1[idx] : model0[idx];
		compare({"transpose_en_out_", port}, 4'(te_out), e.msb, where);
		compare({"t_c_din_", port}, din, exp_din, where);
		// Set fold sign means the restored word is inverted
		compare({"t_c_", port}, tc, e.msb[0] ? ~exp_din : exp_din, where);
	endtask

	task automatic check_result(input int idx);
		pattern_t p;
		string where;
		p = pat_mem[idx];
		where = $sformatf("pattern %0d", idx);
		check_port("a", p.a, p.off[0], t_c_a, t_c_din_a, transpose_en_out_a, where);
		check_port("b", p.b, p.off[0], t_c_b, t_c_din_b, transpose_en_out_b, where);
		compare("read_addr_offset_out", 4'(read_addr_offset_out), p.off, where);
	endtask

	task automatic check_idle(input string where);
		compare("transpose_en_out_a", 4'(transpose_en_out_a), 4'h0, where);
		compare("transpose_en_out_b", 4'(transpose_en_out_b), 4'h0, where);
		compare("read_addr_offset_out", 4'(read_addr_offset_out), 4'h0, where);
	endtask

	////////////////////
	// Stimulus
	////////////////////

	task automatic drive_pattern(input pattern_t p);
		y0_a = p.a.y0;
		y1_a = p.a.y1;
		transpose_en_in_a = p.a.te[0];
		y0_b = p.b.y0;
		y1_b = p.b.y1;
		transpose_en_in_b = p.b.te[0];
		read_addr_offset = p.off[0];
	endtask

	// Random words into every page and offset of both banks
	task automatic fill_table();
		logic [31:0] r;
		logic [6:0] idx;
		for (int i = 0; i < n_entries; i++) begin
			@(negedge read_clk);
			r = $urandom;
			idx = i[6:0];
			lut_in_bank0 = r[3:0];
			lut_in_bank1 = r[7:4];
			page_write_addr = idx[5:0];
			write_addr_offset = idx[6];
			we = 1'b1;
			model0[idx] = r[3:0];
			model1[idx] = r[7:4];
		end
		@(negedge read_clk);
		we = 1'b0;
	endtask

	// One vector per cycle, results checked latency falling edges later
	task automatic run_patterns();
		int idx;
		for (int step = 0; step < n_pat + latency; step++) begin
			@(negedge read_clk);
			if (pend_q.size() == latency) begin
				idx = pend_q.pop_front();
				if (idx >= 0) begin
					check_result(idx);
				end
			end
			if (step < n_pat) begin
				drive_pattern(pat_mem[step]);
				pend_q.push_back(step);
			end else begin
				drive_pattern('0);
				pend_q.push_back(-1);
			end
		end
	endtask

	initial begin
		drive_pattern('0);
		lut_in_bank0 = '0;
		lut_in_bank1 = '0;
		page_write_addr = '0;
		write_addr_offset = 1'b0;
		we = 1'b0;
		// All ones marks a line the file did not fill
		for (int i = 0; i < n_pat; i++) begin
			pat_mem[i] = '1;
		end
		$readmemh("tests/vn_lut_patterns.txt", pat_mem);
		void'($urandom(32'hfb7d25f7));
		wait (rst_n === 1'b1);
		@(negedge read_clk);
		check_idle("end of reset");
		fill_table();
		check_idle("end of table fill");
		if (pat_mem[n_pat-1] === '1) begin
			$display("pattern file is missing or holds fewer than %0d vectors", n_pat);
			other_errors++;
		end else begin
			run_patterns();
		end
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Run limit
	always @(posedge read_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("run did not finish within %0d cycles", cycle_limit);
			$display("value errors: %0d, other errors: %0d", value_errors, other_errors + 1);
			$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
	parameter int half_period = 2,
	parameter int reset_cycles = 16
) (
	output logic read_clk,
	output logic rst_n
);

	// 4 ns period
	initial begin
		read_clk = 1'b0;
		forever #half_period read_clk = ~read_clk;
	end

	// Reset held over the first rising edges
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge read_clk);
		// Released between edges
		@(negedge read_clk);
		rst_n = 1'b1;
	end

endmodule

// ==== logic/sym_vn_lut.sv ====
`timescale 1ns/1ns

module sym_vn_lut (
	input logic read_clk,
	input logic rst_n,
	// Read side
	input vn_lut_pkg::msg_t y0_a,
	input vn_lut_pkg::msg_t y1_a,
	input vn_lut_pkg::msg_t y0_b,
	input vn_lut_pkg::msg_t y1_b,
	input logic transpose_en_in_a,
	input logic transpose_en_in_b,
	input logic read_addr_offset,
	// Write side
	input vn_lut_pkg::lut_word_t lut_in_bank0,
	input vn_lut_pkg::lut_word_t lut_in_bank1,
	input vn_lut_pkg::page_t page_write_addr,
	input logic write_addr_offset,
	input logic we,
	// Results, three cycles after the inputs
	output vn_lut_pkg::lut_word_t t_c_a,
	output vn_lut_pkg::lut_word_t t_c_din_a,
	output vn_lut_pkg::lut_word_t t_c_b,
	output vn_lut_pkg::lut_word_t t_c_din_b,
	output logic transpose_en_out_a,
	output logic transpose_en_out_b,
	output logic read_addr_offset_out
);

	vn_lut_pkg::vn_read_t rd_a;
	vn_lut_pkg::vn_read_t rd_b;
	vn_lut_pkg::vn_word_t word_a;
	vn_lut_pkg::vn_word_t word_b;
	vn_lut_pkg::lut_write_t wr;
	logic offset_pipe;

	// Write fields gathered into one packet
	assign wr = '{data0: lut_in_bank0, data1: lut_in_bank1,
		page: page_write_addr, offset: write_addr_offset};

	////////////////////
	// Pipeline
	////////////////////

	// Stage 0, fold and address
	vn_msg_fold i_fold (
		.read_clk(read_clk), .rst_n(rst_n),
		.y0_a(y0_a), .y1_a(y1_a), .transpose_en_a(transpose_en_in_a),
		.y0_b(y0_b), .y1_b(y1_b), .transpose_en_b(transpose_en_in_b),
		.read_addr_offset(read_addr_offset),
		.rd_a(rd_a), .rd_b(rd_b)
	);

	// Stage 1, table read
	vn_lut_bank i_bank (
		.read_clk(read_clk), .rst_n(rst_n),
		.rd_a(rd_a), .rd_b(rd_b), .wr(wr), .we(we),
		.word_a(word_a), .word_b(word_b), .offset_out(offset_pipe)
	);

	// Stage 2, sign restore
	vn_msg_unfold i_unfold (
		.read_clk(read_clk), .rst_n(rst_n),
		.word_a(word_a), .word_b(word_b), .offset_in(offset_pipe),
		.t_c_a(t_c_a), .t_c_din_a(t_c_din_a), .transpose_en_out_a(transpose_en_out_a),
		.t_c_b(t_c_b), .t_c_din_b(t_c_din_b), .transpose_en_out_b(transpose_en_out_b),
		.read_addr_offset_out(read_addr_offset_out)
	);

endmodule

// ==== logic/vn_msg_unfold.sv ====
`timescale 1ns/1ns

module vn_msg_unfold (
	input logic read_clk,
	input logic rst_n,
	// Read results from the table
	input vn_lut_pkg::vn_word_t word_a,
	input vn_lut_pkg::vn_word_t word_b,
	input logic offset_in,
	// Port A outputs
	output vn_lut_pkg::lut_word_t t_c_a,
	output vn_lut_pkg::lut_word_t t_c_din_a,
	output logic transpose_en_out_a,
	// Port B outputs
	output vn_lut_pkg::lut_word_t t_c_b,
	output vn_lut_pkg::lut_word_t t_c_din_b,
	output logic transpose_en_out_b,
	output logic read_addr_offset_out
);

	// Undo the fold, inverted word when the fold sign was set
	function automatic vn_lut_pkg::lut_word_t restore(input vn_lut_pkg::vn_word_t w);
		return w.msb ? ~w.word : w.word;
	endfunction

	////////////////////
	// Stage 2 registers
	////////////////////

	always_ff @(posedge read_clk) begin
		if (!rst_n) begin
			t_c_a <= '0;
			t_c_b <= '0;
			t_c_din_a <= '0;
			t_c_din_b <= '0;
			transpose_en_out_a <= 1'b0;
			transpose_en_out_b <= 1'b0;
			read_addr_offset_out <= 1'b0;
		end else begin
			t_c_a <= restore(word_a);
			t_c_b <= restore(word_b);
			// Raw words for the decision node
			t_c_din_a <= word_a.word;
			t_c_din_b <= word_b.word;
			transpose_en_out_a <= word_a.msb;
			transpose_en_out_b <= word_b.msb;
			read_addr_offset_out <= offset_in;
		end
	end

endmodule

// ==== logic/vn_lut_bank.sv ====
`timescale 1ns/1ns
`include "vn_lut_macros.svh"

module vn_lut_bank (
	input logic read_clk,
	input logic rst_n,
	// Read requests from the fold stage
	input vn_lut_pkg::vn_read_t rd_a,
	input vn_lut_pkg::vn_read_t rd_b,
	// Page write, both banks
	input vn_lut_pkg::lut_write_t wr,
	input logic we,
	// Registered read results
	output vn_lut_pkg::vn_word_t word_a,
	output vn_lut_pkg::vn_word_t word_b,
	output logic offset_out
);

	////////////////////
	// Storage
	////////////////////

	// Each bank holds both offsets, offset is the top index bit
	vn_lut_pkg::lut_word_t mem0 [2*`VN_PAGES];
	vn_lut_pkg::lut_word_t mem1 [2*`VN_PAGES];

	logic [`VN_PAGE_W:0] wr_idx;
	logic [`VN_PAGE_W:0] rd_idx_a;
	logic [`VN_PAGE_W:0] rd_idx_b;

	// Offset then page
	assign wr_idx = {wr.offset, wr.page};
	assign rd_idx_a = {rd_a.addr.offset, rd_a.addr.page};
	assign rd_idx_b = {rd_b.addr.offset, rd_b.addr.page};

	// Write both banks at the same page
	always_ff @(posedge read_clk) begin
		if (we) begin
			mem0[wr_idx] <= wr.data0;
			mem1[wr_idx] <= wr.data1;
		end
	end

	////////////////////
	// Stage 1 reads
	////////////////////

	// Registered reads, old word on a same-edge write
	always_ff @(posedge read_clk) begin
		if (rd_a.addr.bank) begin
			word_a.word <= mem1[rd_idx_a];
		end else begin
			word_a.word <= mem0[rd_idx_a];
		end
		if (rd_b.addr.bank) begin
			word_b.word <= mem1[rd_idx_b];
		end else begin
			word_b.word <= mem0[rd_idx_b];
		end
	end

	// Sideband travels alongside the read
	always_ff @(posedge read_clk) begin
		if (!rst_n) begin
			word_a.msb <= 1'b0;
			word_b.msb <= 1'b0;
			offset_out <= 1'b0;
		end else begin
			word_a.msb <= rd_a.msb;
			word_b.msb <= rd_b.msb;
			// Both ports share one offset, take it from port A
			offset_out <= rd_a.addr.offset;
		end
	end

endmodule

// ==== logic/vn_msg_fold.sv ====
`timescale 1ns/1ns
`include "vn_lut_macros.svh"

module vn_msg_fold (
	input logic read_clk,
	input logic rst_n,
	// Port A messages
	input vn_lut_pkg::msg_t y0_a,
	input vn_lut_pkg::msg_t y1_a,
	input logic transpose_en_a,
	// Port B messages
	input vn_lut_pkg::msg_t y0_b,
	input vn_lut_pkg::msg_t y1_b,
	input logic transpose_en_b,
	// Offset shared by both ports
	input logic read_addr_offset,
	// Registered requests into the table
	output vn_lut_pkg::vn_read_t rd_a,
	output vn_lut_pkg::vn_read_t rd_b
);

	////////////////////
	// Folding
	////////////////////

	// Fold one message pair into its half-table and form the address
	function automatic vn_lut_pkg::vn_read_t fold_port(
		input vn_lut_pkg::msg_t y0,
		input vn_lut_pkg::msg_t y1,
		input logic transpose_en,
		input logic offset
	);
		vn_lut_pkg::vn_read_t req;
		vn_lut_pkg::mag_t y0_mag;
		vn_lut_pkg::msg_t y1_fold;
		logic msb;

		// Fold sign, also the transpose flag carried to the output
		msb = transpose_en ^ y0[`VN_MSG_W-1];
		// Negative y0 mirrors onto the positive half
		y0_mag = y0[`VN_MAG_W-1:0] ^ {`VN_MAG_W{y0[`VN_MSG_W-1]}};
		// y1 follows the fold sign
		y1_fold = msb ? ~y1 : y1;

		// Top bit of folded y1 picks the bank
		req.addr.bank = y1_fold[`VN_MSG_W-1];
		// Page is y0 magnitude over low y1 bits
		req.addr.page = {y0_mag, y1_fold[`VN_MSG_W-2:0]};
		req.addr.offset = offset;
		req.msb = msb;
		return req;
	endfunction

	vn_lut_pkg::vn_read_t fold_a;
	vn_lut_pkg::vn_read_t fold_b;

	always_comb begin
		fold_a = fold_port(y0_a, y1_a, transpose_en_a, read_addr_offset);
		fold_b = fold_port(y0_b, y1_b, transpose_en_b, read_addr_offset);
	end

	////////////////////
	// Stage 0 registers
	////////////////////

	always_ff @(posedge read_clk) begin
		if (!rst_n) begin
			rd_a <= '0;
			rd_b <= '0;
		end else begin
			// New request every cycle, no stall
			rd_a <= fold_a;
			rd_b <= fold_b;
		end
	end

endmodule

// ==== logic/vn_lut_pkg.sv ====
`include "vn_lut_macros.svh"

package vn_lut_pkg;

	// Channel message, sign in the top bit
	typedef logic [`VN_MSG_W-1:0] msg_t;
	// Folded y0 magnitude
	typedef logic [`VN_MAG_W-1:0] mag_t;
	// Page address inside one bank half
	typedef logic [`VN_PAGE_W-1:0] page_t;
	// Table entry, same width as a message
	typedef logic [`VN_MSG_W-1:0] lut_word_t;

	// One read address
	typedef struct packed {
		logic bank;
		page_t page;
		logic offset;
	} vn_addr_t;

	// Read request, producer to buffer
	typedef struct packed {
		vn_addr_t addr;
		logic msb;
	} vn_read_t;

	// Read result, buffer to consumer
	typedef struct packed {
		lut_word_t word;
		logic msb;
	} vn_word_t;

	// One page write, both banks at once
	typedef struct packed {
		lut_word_t data0;
		lut_word_t data1;
		page_t page;
		logic offset;
	} lut_write_t;

endpackage

// ==== logic/vn_lut_macros.svh ====
`ifndef VN_LUT_MACROS_SVH
`define VN_LUT_MACROS_SVH

////////////////////
// Message widths
////////////////////

// Channel message, sign-magnitude with sign on top
`define VN_MSG_W 4

// Folded y0 magnitude
`define VN_MAG_W 3

////////////////////
// Table geometry
////////////////////

// Page address width
`define VN_PAGE_W 6
// Pages per bank and per offset
`define VN_PAGES 64

`endif
